/* mci_wdt_pkg.sv */
// Register map, widths and shared types for the watchdog and error block, used by every RTL file
`default_nettype none

package mci_wdt_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int REG_ADDR_WIDTH    = 5;
    localparam int REG_DATA_WIDTH    = 32;
    localparam int WDT_PERIOD_DWORDS = 2;
    localparam int WDT_PERIOD_WIDTH  = WDT_PERIOD_DWORDS * REG_DATA_WIDTH;

    typedef logic [REG_ADDR_WIDTH-1:0]   reg_addr_t;
    typedef logic [REG_DATA_WIDTH-1:0]   reg_data_t;
    typedef logic [WDT_PERIOD_WIDTH-1:0] wdt_period_t;

    ////////////////////
    // Word addresses
    ////////////////////

    // Timer 1
    localparam reg_addr_t ADDR_T1_EN        = 5'd0;
    localparam reg_addr_t ADDR_T1_CTRL      = 5'd1;
    localparam reg_addr_t ADDR_T1_PERIOD_LO = 5'd2;
    localparam reg_addr_t ADDR_T1_PERIOD_HI = 5'd3;

    // Timer 2
    localparam reg_addr_t ADDR_T2_EN        = 5'd4;
    localparam reg_addr_t ADDR_T2_CTRL      = 5'd5;
    localparam reg_addr_t ADDR_T2_PERIOD_LO = 5'd6;
    localparam reg_addr_t ADDR_T2_PERIOD_HI = 5'd7;

    // Bit 0 is timer 1, bit 1 is timer 2, W1C services the timer
    localparam reg_addr_t ADDR_WDT_STATUS = 5'd8;

    // Error aggregation
    localparam reg_addr_t ADDR_ERR_FATAL_MASK     = 5'd9;
    localparam reg_addr_t ADDR_ERR_NON_FATAL_MASK = 5'd10;
    localparam reg_addr_t ADDR_ERR_FATAL_STS      = 5'd11;
    localparam reg_addr_t ADDR_ERR_NON_FATAL_STS  = 5'd12;

    // Interrupts
    localparam reg_addr_t ADDR_INTR_EN    = 5'd13;
    localparam reg_addr_t ADDR_NMI_VECTOR = 5'd14;

endpackage

`default_nettype wire

/* mci_wdt_ctrl_if.sv */
// Watchdog controls and timeout status passed between the register bank and the watchdog
`default_nettype none
`timescale 1ns/10ps

interface mci_wdt_ctrl_if;

    // Levels from the register bank
    logic                     t1_en;
    logic                     t2_en;
    mci_wdt_pkg::wdt_period_t t1_period;
    mci_wdt_pkg::wdt_period_t t2_period;

    // Single cycle pulses
    logic t1_restart;
    logic t2_restart;
    logic t1_serviced;
    logic t2_serviced;

    // Sticky timeouts back from the watchdog
    logic t1_timeout;
    logic t2_timeout;

    modport regs (
        output t1_en, t2_en, t1_period, t2_period,
        output t1_restart, t2_restart, t1_serviced, t2_serviced,
        input  t1_timeout, t2_timeout
    );

    modport wdt (
        input  t1_en, t2_en, t1_period, t2_period,
        input  t1_restart, t2_restart, t1_serviced, t2_serviced,
        output t1_timeout, t2_timeout
    );

endinterface

`default_nettype wire

/* mci_err_ctrl_if.sv */
// Error masks, W1C clears, interrupt enables and sticky status between register bank and aggregator
`default_nettype none
`timescale 1ns/10ps

interface mci_err_ctrl_if #(
    parameter int AGG_ERR_WIDTH = 32
);

    // Levels from the register bank
    logic [AGG_ERR_WIDTH-1:0] fatal_mask;
    logic [AGG_ERR_WIDTH-1:0] non_fatal_mask;
    logic [1:0]               intr_en;

    // Bit vectors valid for one cycle after a W1C write
    logic [AGG_ERR_WIDTH-1:0] fatal_clr;
    logic [AGG_ERR_WIDTH-1:0] non_fatal_clr;

    // Sticky status from the aggregator
    logic [AGG_ERR_WIDTH-1:0] fatal_sts;
    logic [AGG_ERR_WIDTH-1:0] non_fatal_sts;

    modport regs (
        output fatal_mask, non_fatal_mask, intr_en,
        output fatal_clr, non_fatal_clr,
        input  fatal_sts, non_fatal_sts
    );

    modport agg (
        input  fatal_mask, non_fatal_mask, intr_en,
        input  fatal_clr, non_fatal_clr,
        output fatal_sts, non_fatal_sts
    );

endinterface

`default_nettype wire

/* mci_wdt_counter.sv */
// Single watchdog period counter with a sticky timeout flag, instantiated once per timer
`default_nettype none
`timescale 1ns/10ps

module mci_wdt_counter #(
    parameter int CNT_WIDTH = 64
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n_i,
    input  wire logic                 run_i,
    input  wire logic                 restart_i,
    input  wire logic                 serviced_i,
    input  wire logic [CNT_WIDTH-1:0] period_i,
    output logic                      timeout_o
);

    logic [CNT_WIDTH-1:0] count_q;
    logic                 timeout_q;
    logic                 cnt_clr;
    logic                 cnt_hit;

    assign cnt_clr = !run_i || restart_i || serviced_i;
    assign cnt_hit = (count_q == period_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (cnt_clr) begin
            count_q <= '0;
        end else if (!timeout_q && !cnt_hit) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Sticky until serviced, a stop or a restart leaves it set
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            timeout_q <= 1'b0;
        end else if (serviced_i) begin
            timeout_q <= 1'b0;
        end else if (!cnt_clr && cnt_hit) begin
            timeout_q <= 1'b1;
        end
    end

    assign timeout_o = timeout_q;

endmodule

`default_nettype wire

/* mci_wdt.sv */
// Two stage watchdog, timer 2 runs on its own enable or in cascade after a timer 1 timeout
`default_nettype none
`timescale 1ns/10ps

module mci_wdt (
    input  wire logic   clk,
    input  wire logic   arst_n_i,
    mci_wdt_ctrl_if.wdt wdt_ctrl
);

    logic t1_run;
    logic t2_run;

    // Timer 1 counts whenever enabled
    assign t1_run = wdt_ctrl.t1_en;

    // Cascade mode when timer 2 is left disabled
    assign t2_run = wdt_ctrl.t2_en || wdt_ctrl.t1_timeout;

    mci_wdt_counter #(
        .CNT_WIDTH (mci_wdt_pkg::WDT_PERIOD_WIDTH)
    ) u_timer1 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .run_i      (t1_run),
        .restart_i  (wdt_ctrl.t1_restart),
        .serviced_i (wdt_ctrl.t1_serviced),
        .period_i   (wdt_ctrl.t1_period),
        .timeout_o  (wdt_ctrl.t1_timeout)
    );

    mci_wdt_counter #(
        .CNT_WIDTH (mci_wdt_pkg::WDT_PERIOD_WIDTH)
    ) u_timer2 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .run_i      (t2_run),
        .restart_i  (wdt_ctrl.t2_restart),
        .serviced_i (wdt_ctrl.t2_serviced),
        .period_i   (wdt_ctrl.t2_period),
        .timeout_o  (wdt_ctrl.t2_timeout)
    );

endmodule

`default_nettype wire

/* mci_error_agg.sv */
// Sticky error capture with masking, drives the registered error outputs and watchdog interrupt
`default_nettype none
`timescale 1ns/10ps

module mci_error_agg #(
    parameter int AGG_ERR_WIDTH = 32
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n_i,
    input  wire logic [AGG_ERR_WIDTH-1:0] agg_error_fatal_i,
    input  wire logic [AGG_ERR_WIDTH-1:0] agg_error_non_fatal_i,
    input  wire logic                     t1_timeout_i,
    input  wire logic                     t2_timeout_i,
    output logic                          mci_intr_o,
    output logic                          all_error_fatal_o,
    output logic                          all_error_non_fatal_o,
    mci_err_ctrl_if.agg                   err_ctrl
);

    logic [AGG_ERR_WIDTH-1:0] fatal_sts_q;
    logic [AGG_ERR_WIDTH-1:0] non_fatal_sts_q;

    ////////////////////
    // Sticky status
    ////////////////////

    // A new error on the same edge wins over the clear
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fatal_sts_q     <= '0;
            non_fatal_sts_q <= '0;
        end else begin
            fatal_sts_q     <= (fatal_sts_q & ~err_ctrl.fatal_clr) | agg_error_fatal_i;
            non_fatal_sts_q <= (non_fatal_sts_q & ~err_ctrl.non_fatal_clr)
                               | agg_error_non_fatal_i;
        end
    end

    assign err_ctrl.fatal_sts     = fatal_sts_q;
    assign err_ctrl.non_fatal_sts = non_fatal_sts_q;

    ////////////////////
    // Outputs
    ////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            all_error_fatal_o     <= 1'b0;
            all_error_non_fatal_o <= 1'b0;
            mci_intr_o            <= 1'b0;
        end else begin
            all_error_fatal_o     <= |(fatal_sts_q & ~err_ctrl.fatal_mask);
            all_error_non_fatal_o <= |(non_fatal_sts_q & ~err_ctrl.non_fatal_mask);
            // Enable bit 0 gates timer 1, bit 1 gates timer 2
            mci_intr_o            <= |({t2_timeout_i, t1_timeout_i} & err_ctrl.intr_en);
        end
    end

endmodule

`default_nettype wire

/* mci_reg_bank.sv */
// Register bus decoder and control register file that drives the watchdog and error interfaces
`default_nettype none
`timescale 1ns/10ps

module mci_reg_bank #(
    parameter int AGG_ERR_WIDTH = 32
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,

    // Register bus
    input  wire logic                   reg_wr_en_i,
    input  wire logic                   reg_rd_en_i,
    input  wire mci_wdt_pkg::reg_addr_t reg_addr_i,
    input  wire mci_wdt_pkg::reg_data_t reg_wdata_i,
    output mci_wdt_pkg::reg_data_t      reg_rdata_o,

    output mci_wdt_pkg::reg_data_t      mcu_nmi_vector_o,

    mci_wdt_ctrl_if.regs                wdt_ctrl,
    mci_err_ctrl_if.regs                err_ctrl
);

    localparam int DW = mci_wdt_pkg::REG_DATA_WIDTH;
    localparam int ND = mci_wdt_pkg::WDT_PERIOD_DWORDS;

    // Control storage
    logic                     t1_en_q;
    logic                     t2_en_q;
    logic [ND-1:0][DW-1:0]    t1_period_q;
    logic [ND-1:0][DW-1:0]    t2_period_q;
    logic [AGG_ERR_WIDTH-1:0] fatal_mask_q;
    logic [AGG_ERR_WIDTH-1:0] non_fatal_mask_q;
    logic [1:0]               intr_en_q;
    mci_wdt_pkg::reg_data_t   nmi_vector_q;

    // Write side pulses
    logic                     t1_restart_q;
    logic                     t2_restart_q;
    logic                     t1_serviced_q;
    logic                     t2_serviced_q;
    logic [AGG_ERR_WIDTH-1:0] fatal_clr_q;
    logic [AGG_ERR_WIDTH-1:0] non_fatal_clr_q;

    mci_wdt_pkg::reg_data_t   rd_data;
    mci_wdt_pkg::reg_data_t   rdata_q;

    ////////////////////
    // Write decode
    ////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            t1_en_q          <= 1'b0;
            t2_en_q          <= 1'b0;
            t1_period_q      <= '0;
            t2_period_q      <= '0;
            fatal_mask_q     <= '0;
            non_fatal_mask_q <= '0;
            intr_en_q        <= '0;
            nmi_vector_q     <= '0;
            t1_restart_q     <= 1'b0;
            t2_restart_q     <= 1'b0;
            t1_serviced_q    <= 1'b0;
            t2_serviced_q    <= 1'b0;
            fatal_clr_q      <= '0;
            non_fatal_clr_q  <= '0;
        end else begin
            // Pulses last a single cycle unless rewritten below
            t1_restart_q    <= 1'b0;
            t2_restart_q    <= 1'b0;
            t1_serviced_q   <= 1'b0;
            t2_serviced_q   <= 1'b0;
            fatal_clr_q     <= '0;
            non_fatal_clr_q <= '0;
            if (reg_wr_en_i) begin
                case (reg_addr_i)
                    mci_wdt_pkg::ADDR_T1_EN:              t1_en_q <= reg_wdata_i[0];
                    mci_wdt_pkg::ADDR_T1_CTRL:            t1_restart_q <= reg_wdata_i[0];
                    mci_wdt_pkg::ADDR_T1_PERIOD_LO:       t1_period_q[0] <= reg_wdata_i;
                    mci_wdt_pkg::ADDR_T1_PERIOD_HI:       t1_period_q[1] <= reg_wdata_i;
                    mci_wdt_pkg::ADDR_T2_EN:              t2_en_q <= reg_wdata_i[0];
                    mci_wdt_pkg::ADDR_T2_CTRL:            t2_restart_q <= reg_wdata_i[0];
                    mci_wdt_pkg::ADDR_T2_PERIOD_LO:       t2_period_q[0] <= reg_wdata_i;
                    mci_wdt_pkg::ADDR_T2_PERIOD_HI:       t2_period_q[1] <= reg_wdata_i;
                    mci_wdt_pkg::ADDR_WDT_STATUS: begin
                        t1_serviced_q <= reg_wdata_i[0];
                        t2_serviced_q <= reg_wdata_i[1];
                    end
                    mci_wdt_pkg::ADDR_ERR_FATAL_MASK: begin
                        fatal_mask_q <= reg_wdata_i[AGG_ERR_WIDTH-1:0];
                    end
                    mci_wdt_pkg::ADDR_ERR_NON_FATAL_MASK: begin
                        non_fatal_mask_q <= reg_wdata_i[AGG_ERR_WIDTH-1:0];
                    end
                    mci_wdt_pkg::ADDR_ERR_FATAL_STS: begin
                        fatal_clr_q <= reg_wdata_i[AGG_ERR_WIDTH-1:0];
                    end
                    mci_wdt_pkg::ADDR_ERR_NON_FATAL_STS: begin
                        non_fatal_clr_q <= reg_wdata_i[AGG_ERR_WIDTH-1:0];
                    end
                    mci_wdt_pkg::ADDR_INTR_EN:            intr_en_q <= reg_wdata_i[1:0];
                    mci_wdt_pkg::ADDR_NMI_VECTOR:         nmi_vector_q <= reg_wdata_i;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////
    // Read mux
    ////////////////////

    // Control words read as zero, as do unmapped addresses
    always_comb begin
        rd_data = '0;
        case (reg_addr_i)
            mci_wdt_pkg::ADDR_T1_EN:              rd_data[0] = t1_en_q;
            mci_wdt_pkg::ADDR_T1_PERIOD_LO:       rd_data = t1_period_q[0];
            mci_wdt_pkg::ADDR_T1_PERIOD_HI:       rd_data = t1_period_q[1];
            mci_wdt_pkg::ADDR_T2_EN:              rd_data[0] = t2_en_q;
            mci_wdt_pkg::ADDR_T2_PERIOD_LO:       rd_data = t2_period_q[0];
            mci_wdt_pkg::ADDR_T2_PERIOD_HI:       rd_data = t2_period_q[1];
            mci_wdt_pkg::ADDR_WDT_STATUS: begin
                rd_data[1:0] = {wdt_ctrl.t2_timeout, wdt_ctrl.t1_timeout};
            end
            mci_wdt_pkg::ADDR_ERR_FATAL_MASK:     rd_data = DW'(fatal_mask_q);
            mci_wdt_pkg::ADDR_ERR_NON_FATAL_MASK: rd_data = DW'(non_fatal_mask_q);
            mci_wdt_pkg::ADDR_ERR_FATAL_STS:      rd_data = DW'(err_ctrl.fatal_sts);
            mci_wdt_pkg::ADDR_ERR_NON_FATAL_STS:  rd_data = DW'(err_ctrl.non_fatal_sts);
            mci_wdt_pkg::ADDR_INTR_EN:            rd_data[1:0] = intr_en_q;
            mci_wdt_pkg::ADDR_NMI_VECTOR:         rd_data = nmi_vector_q;
            default: ;
        endcase
    end

    // Holds the last read word
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '0;
        end else if (reg_rd_en_i) begin
            rdata_q <= rd_data;
        end
    end

    assign reg_rdata_o      = rdata_q;
    assign mcu_nmi_vector_o = nmi_vector_q;

    // Watchdog side
    assign wdt_ctrl.t1_en       = t1_en_q;
    assign wdt_ctrl.t2_en       = t2_en_q;
    assign wdt_ctrl.t1_period   = t1_period_q;
    assign wdt_ctrl.t2_period   = t2_period_q;
    assign wdt_ctrl.t1_restart  = t1_restart_q;
    assign wdt_ctrl.t2_restart  = t2_restart_q;
    assign wdt_ctrl.t1_serviced = t1_serviced_q;
    assign wdt_ctrl.t2_serviced = t2_serviced_q;

    // Error side
    assign err_ctrl.fatal_mask     = fatal_mask_q;
    assign err_ctrl.non_fatal_mask = non_fatal_mask_q;
    assign err_ctrl.intr_en        = intr_en_q;
    assign err_ctrl.fatal_clr      = fatal_clr_q;
    assign err_ctrl.non_fatal_clr  = non_fatal_clr_q;

endmodule

`default_nettype wire

/* mci_wdt_top.sv */
// Top level of the watchdog and error aggregation block, instantiate this in the system
`default_nettype none
`timescale 1ns/10ps

module mci_wdt_top #(
    parameter int AGG_ERR_WIDTH = 32
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n_i,

    // Register bus
    input  wire logic                     reg_wr_en_i,
    input  wire logic                     reg_rd_en_i,
    input  wire mci_wdt_pkg::reg_addr_t   reg_addr_i,
    input  wire mci_wdt_pkg::reg_data_t   reg_wdata_i,
    output mci_wdt_pkg::reg_data_t        reg_rdata_o,

    // Subsystem error buses
    input  wire logic [AGG_ERR_WIDTH-1:0] agg_error_fatal_i,
    input  wire logic [AGG_ERR_WIDTH-1:0] agg_error_non_fatal_i,

    // Interrupts and errors
    output logic                          nmi_intr_o,
    output mci_wdt_pkg::reg_data_t        mcu_nmi_vector_o,
    output logic                          mci_intr_o,
    output logic                          all_error_fatal_o,
    output logic                          all_error_non_fatal_o
);

    logic t1_timeout;
    logic t2_timeout;

    mci_wdt_ctrl_if wdt_ctrl ();

    mci_err_ctrl_if #(
        .AGG_ERR_WIDTH (AGG_ERR_WIDTH)
    ) err_ctrl ();

    assign t1_timeout = wdt_ctrl.t1_timeout;
    assign t2_timeout = wdt_ctrl.t2_timeout;

    // Timer 2 expiry is the NMI
    assign nmi_intr_o = t2_timeout;

    mci_reg_bank #(
        .AGG_ERR_WIDTH (AGG_ERR_WIDTH)
    ) u_reg_bank (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .reg_wr_en_i      (reg_wr_en_i),
        .reg_rd_en_i      (reg_rd_en_i),
        .reg_addr_i       (reg_addr_i),
        .reg_wdata_i      (reg_wdata_i),
        .reg_rdata_o      (reg_rdata_o),
        .mcu_nmi_vector_o (mcu_nmi_vector_o),
        .wdt_ctrl         (wdt_ctrl.regs),
        .err_ctrl         (err_ctrl.regs)
    );

    mci_wdt u_wdt (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wdt_ctrl (wdt_ctrl.wdt)
    );

    mci_error_agg #(
        .AGG_ERR_WIDTH (AGG_ERR_WIDTH)
    ) u_error_agg (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .agg_error_fatal_i     (agg_error_fatal_i),
        .agg_error_non_fatal_i (agg_error_non_fatal_i),
        .t1_timeout_i          (t1_timeout),
        .t2_timeout_i          (t2_timeout),
        .mci_intr_o            (mci_intr_o),
        .all_error_fatal_o     (all_error_fatal_o),
        .all_error_non_fatal_o (all_error_non_fatal_o),
        .err_ctrl              (err_ctrl.agg)
    );

endmodule

`default_nettype wire

/* tb_mci_wdt_top.sv */
// Directed testbench that runs as the simulation top around the watchdog and error top level
`default_nettype none
`timescale 1ns/10ps

module tb_mci_wdt_top;

    localparam int AGG_ERR_WIDTH = 32;
    // Tests take a few hundred cycles
    localparam int CYCLE_LIMIT   = 3000;

    logic                     clk;
    logic                     arst_n_i;
    logic                     reg_wr_en_i;
    logic                     reg_rd_en_i;
    mci_wdt_pkg::reg_addr_t   reg_addr_i;
    mci_wdt_pkg::reg_data_t   reg_wdata_i;
    mci_wdt_pkg::reg_data_t   reg_rdata_o;
    logic [AGG_ERR_WIDTH-1:0] agg_error_fatal_i;
    logic [AGG_ERR_WIDTH-1:0] agg_error_non_fatal_i;
    logic                     nmi_intr_o;
    mci_wdt_pkg::reg_data_t   mcu_nmi_vector_o;
    logic                     mci_intr_o;
    logic                     all_error_fatal_o;
    logic                     all_error_non_fatal_o;

    logic [31:0] rng_state;
    int          cycle_cnt;

    mci_wdt_top #(
        .AGG_ERR_WIDTH (AGG_ERR_WIDTH)
    ) dut_i (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .reg_wr_en_i           (reg_wr_en_i),
        .reg_rd_en_i           (reg_rd_en_i),
        .reg_addr_i            (reg_addr_i),
        .reg_wdata_i           (reg_wdata_i),
        .reg_rdata_o           (reg_rdata_o),
        .agg_error_fatal_i     (agg_error_fatal_i),
        .agg_error_non_fatal_i (agg_error_non_fatal_i),
        .nmi_intr_o            (nmi_intr_o),
        .mcu_nmi_vector_o      (mcu_nmi_vector_o),
        .mci_intr_o            (mci_intr_o),
        .all_error_fatal_o     (all_error_fatal_o),
        .all_error_non_fatal_o (all_error_non_fatal_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Period between 4 and 20 cycles
    function automatic int rand_period();
        return 4 + int'(xorshift() % 17);
    endfunction

    function automatic logic error_output(input bit fatal);
        return fatal ? all_error_fatal_o : all_error_non_fatal_o;
    endfunction

    // Bus tasks take one cycle from falling edge to falling edge
    task automatic reg_write(input mci_wdt_pkg::reg_addr_t addr,
                             input mci_wdt_pkg::reg_data_t data);
        reg_wr_en_i = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk);
        reg_wr_en_i = 1'b0;
    endtask

    task automatic reg_read(input mci_wdt_pkg::reg_addr_t addr,
                            output mci_wdt_pkg::reg_data_t data);
        reg_rd_en_i = 1'b1;
        reg_addr_i  = addr;
        @(negedge clk);
        reg_rd_en_i = 1'b0;
        data = reg_rdata_o;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic write_read_check(input mci_wdt_pkg::reg_addr_t addr,
                                    input mci_wdt_pkg::reg_data_t data,
                                    input mci_wdt_pkg::reg_data_t expected,
                                    input string name);
        mci_wdt_pkg::reg_data_t rd;
        reg_write(addr, data);
        reg_read(addr, rd);
        check(name, rd, expected);
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic register_readback();
        mci_wdt_pkg::reg_data_t val;
        val = xorshift();
        write_read_check(mci_wdt_pkg::ADDR_T1_PERIOD_LO, val, val, "t1_period_lo");
        val = xorshift();
        write_read_check(mci_wdt_pkg::ADDR_T1_PERIOD_HI, val, val, "t1_period_hi");
        val = xorshift();
        write_read_check(mci_wdt_pkg::ADDR_T2_PERIOD_LO, val, val, "t2_period_lo");
        val = xorshift();
        write_read_check(mci_wdt_pkg::ADDR_T2_PERIOD_HI, val, val, "t2_period_hi");
        // Only bit 0 of an enable is stored
        write_read_check(mci_wdt_pkg::ADDR_T1_EN, 32'hffff_ffff, 32'h1, "t1_en");
        write_read_check(mci_wdt_pkg::ADDR_T1_EN, 32'hffff_fffe, 32'h0, "t1_en");
        write_read_check(mci_wdt_pkg::ADDR_T2_EN, 32'hffff_ffff, 32'h1, "t2_en");
        write_read_check(mci_wdt_pkg::ADDR_T2_EN, 32'hffff_fffe, 32'h0, "t2_en");
        val = xorshift();
        write_read_check(mci_wdt_pkg::ADDR_ERR_FATAL_MASK, val, val, "fatal_mask");
        val = xorshift();
        write_read_check(mci_wdt_pkg::ADDR_ERR_NON_FATAL_MASK, val, val, "non_fatal_mask");
        val = xorshift();
        write_read_check(mci_wdt_pkg::ADDR_INTR_EN, val, val & 32'h3, "intr_en");
        val = xorshift();
        write_read_check(mci_wdt_pkg::ADDR_NMI_VECTOR, val, val, "nmi_vector");
        check("mcu_nmi_vector_o", mcu_nmi_vector_o, val);
        // Control words and holes in the map read as zero
        write_read_check(mci_wdt_pkg::ADDR_T1_CTRL, 32'h1, 32'h0, "t1_ctrl");
        write_read_check(mci_wdt_pkg::ADDR_T2_CTRL, 32'h1, 32'h0, "t2_ctrl");
        write_read_check(5'd20, xorshift(), 32'h0, "unmapped 20");
        write_read_check(5'd31, xorshift(), 32'h0, "unmapped 31");
        reg_write(mci_wdt_pkg::ADDR_ERR_FATAL_MASK, '0);
        reg_write(mci_wdt_pkg::ADDR_ERR_NON_FATAL_MASK, '0);
        reg_write(mci_wdt_pkg::ADDR_INTR_EN, '0);
        reg_write(mci_wdt_pkg::ADDR_WDT_STATUS, 32'h3);
    endtask

    task automatic timer1_expiry();
        int                     p;
        mci_wdt_pkg::reg_data_t rd;
        p = rand_period();
        reg_write(mci_wdt_pkg::ADDR_T1_PERIOD_LO, p);
        reg_write(mci_wdt_pkg::ADDR_T1_PERIOD_HI, '0);
        // Keeps the cascaded timer 2 far from expiry
        reg_write(mci_wdt_pkg::ADDR_T2_PERIOD_HI, 32'hffff_ffff);
        reg_write(mci_wdt_pkg::ADDR_T1_EN, 32'h1);
        idle_cycles(p);
        // Read edges E+P+1 and E+P+2 return the status after E+P and E+P+1
        reg_read(mci_wdt_pkg::ADDR_WDT_STATUS, rd);
        check("wdt_status before timeout", rd, 32'h0);
        reg_read(mci_wdt_pkg::ADDR_WDT_STATUS, rd);
        check("wdt_status at timeout", rd, 32'h1);
        check("mci_intr_o disabled", mci_intr_o, 1'b0);
        reg_write(mci_wdt_pkg::ADDR_INTR_EN, 32'h1);
        idle_cycles(1);
        check("mci_intr_o enabled", mci_intr_o, 1'b1);

        // Service clears the timeout one edge later and the interrupt one edge after that
        reg_write(mci_wdt_pkg::ADDR_WDT_STATUS, 32'h1);
        idle_cycles(2);
        check("mci_intr_o after service", mci_intr_o, 1'b0);
        reg_read(mci_wdt_pkg::ADDR_WDT_STATUS, rd);
        check("wdt_status after service", rd, 32'h0);
        // Counting restarted on the edge after the service
        idle_cycles(p - 2);
        reg_read(mci_wdt_pkg::ADDR_WDT_STATUS, rd);
        check("wdt_status before second timeout", rd, 32'h0);
        reg_read(mci_wdt_pkg::ADDR_WDT_STATUS, rd);
        check("wdt_status at second timeout", rd, 32'h1);
        check("mci_intr_o second timeout", mci_intr_o, 1'b1);
        reg_write(mci_wdt_pkg::ADDR_T1_EN, '0);
        reg_write(mci_wdt_pkg::ADDR_WDT_STATUS, 32'h3);
        reg_write(mci_wdt_pkg::ADDR_INTR_EN, '0);
    endtask

    task automatic timer1_restart();
        int                     p;
        mci_wdt_pkg::reg_data_t rd;
        p = rand_period();
        reg_write(mci_wdt_pkg::ADDR_T1_PERIOD_LO, p);
        reg_write(mci_wdt_pkg::ADDR_T1_EN, 32'h1);
        // One restart every P/2 cycles for at least 3P cycles
        repeat (8) begin
            reg_write(mci_wdt_pkg::ADDR_T1_CTRL, 32'h1);
            reg_read(mci_wdt_pkg::ADDR_WDT_STATUS, rd);
            check("wdt_status with restarts", rd, 32'h0);
            idle_cycles(p / 2 - 2);
        end
        reg_write(mci_wdt_pkg::ADDR_T1_EN, '0);
    endtask

    task automatic timer2_modes();
        int                     p1;
        int                     p2;
        mci_wdt_pkg::reg_data_t rd;
        p1 = rand_period();
        p2 = rand_period();
        reg_write(mci_wdt_pkg::ADDR_T1_PERIOD_LO, p1);
        reg_write(mci_wdt_pkg::ADDR_T2_PERIOD_LO, p2);
        reg_write(mci_wdt_pkg::ADDR_T2_PERIOD_HI, '0);

        // Cascade mode with timer 2 started by the timer 1 timeout
        reg_write(mci_wdt_pkg::ADDR_T1_EN, 32'h1);
        idle_cycles(p1 + 1);
        check("nmi_intr_o at t1 timeout", nmi_intr_o, 1'b0);
        idle_cycles(p2);
        check("nmi_intr_o before cascade timeout", nmi_intr_o, 1'b0);
        idle_cycles(1);
        check("nmi_intr_o cascade timeout", nmi_intr_o, 1'b1);
        reg_read(mci_wdt_pkg::ADDR_WDT_STATUS, rd);
        check("wdt_status cascade", rd, 32'h3);
        reg_write(mci_wdt_pkg::ADDR_T1_EN, '0);
        reg_write(mci_wdt_pkg::ADDR_WDT_STATUS, 32'h3);
        check("nmi_intr_o on service edge", nmi_intr_o, 1'b1);
        idle_cycles(1);
        check("nmi_intr_o after cascade service", nmi_intr_o, 1'b0);

        // Independent mode with timer 1 left disabled
        p2 = rand_period();
        reg_write(mci_wdt_pkg::ADDR_T2_PERIOD_LO, p2);
        reg_write(mci_wdt_pkg::ADDR_T2_EN, 32'h1);
        idle_cycles(p2);
        check("nmi_intr_o before own timeout", nmi_intr_o, 1'b0);
        idle_cycles(1);
        check("nmi_intr_o own timeout", nmi_intr_o, 1'b1);
        reg_read(mci_wdt_pkg::ADDR_WDT_STATUS, rd);
        check("wdt_status independent", rd, 32'h2);
        reg_write(mci_wdt_pkg::ADDR_T2_EN, '0);
        reg_write(mci_wdt_pkg::ADDR_WDT_STATUS, 32'h2);
        idle_cycles(1);
        check("nmi_intr_o after t2 service", nmi_intr_o, 1'b0);
        reg_read(mci_wdt_pkg::ADDR_WDT_STATUS, rd);
        check("wdt_status after t2 service", rd, 32'h0);
    endtask

    task automatic error_capture(input bit fatal, input logic [31:0] mask);
        mci_wdt_pkg::reg_addr_t mask_addr;
        mci_wdt_pkg::reg_addr_t sts_addr;
        mci_wdt_pkg::reg_data_t rd;
        logic [31:0]            pattern;
        logic [31:0]            clr;
        string                  name;
        mask_addr = fatal ? mci_wdt_pkg::ADDR_ERR_FATAL_MASK
                          : mci_wdt_pkg::ADDR_ERR_NON_FATAL_MASK;
        sts_addr  = fatal ? mci_wdt_pkg::ADDR_ERR_FATAL_STS
                          : mci_wdt_pkg::ADDR_ERR_NON_FATAL_STS;
        name      = fatal ? "all_error_fatal_o" : "all_error_non_fatal_o";
        pattern   = xorshift() | 32'h1;
        clr       = xorshift();
        reg_write(mask_addr, mask);
        // One cycle pulse on the error bus
        if (fatal) begin
            agg_error_fatal_i = pattern;
        end else begin
            agg_error_non_fatal_i = pattern;
        end
        @(negedge clk);
        agg_error_fatal_i     = '0;
        agg_error_non_fatal_i = '0;
        idle_cycles(1);
        check(name, error_output(fatal), |(pattern & ~mask));
        reg_read(sts_addr, rd);
        check("error status captured", rd, pattern);
        reg_write(sts_addr, clr);
        idle_cycles(1);
        reg_read(sts_addr, rd);
        check("error status after clear", rd, pattern & ~clr);
        check(name, error_output(fatal), |(pattern & ~clr & ~mask));
        reg_write(sts_addr, 32'hffff_ffff);
        reg_write(mask_addr, '0);
        idle_cycles(1);
        check(name, error_output(fatal), 1'b0);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        rng_state             = 32'h2fcd1428;
        cycle_cnt             = 0;
        arst_n_i              = 1'b0;
        reg_wr_en_i           = 1'b0;
        reg_rd_en_i           = 1'b0;
        reg_addr_i            = '0;
        reg_wdata_i           = '0;
        agg_error_fatal_i     = '0;
        agg_error_non_fatal_i = '0;
        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);

        check("reg_rdata_o after reset", reg_rdata_o, 32'h0);
        check("nmi_intr_o after reset", nmi_intr_o, 1'b0);
        check("mcu_nmi_vector_o after reset", mcu_nmi_vector_o, 32'h0);
        check("mci_intr_o after reset", mci_intr_o, 1'b0);
        check("all_error_fatal_o after reset", all_error_fatal_o, 1'b0);
        check("all_error_non_fatal_o after reset", all_error_non_fatal_o, 1'b0);

        register_readback();
        timer1_expiry();
        timer1_restart();
        timer2_modes();
        error_capture(1'b1, 32'h0);
        error_capture(1'b1, 32'hffff_ffff);
        error_capture(1'b0, 32'h0);
        error_capture(1'b0, 32'hffff_ffff);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* mci_wdt_sub.f */
mci_wdt_pkg.sv
mci_wdt_ctrl_if.sv
mci_err_ctrl_if.sv
mci_wdt_counter.sv
mci_wdt.sv
mci_error_agg.sv
mci_reg_bank.sv
mci_wdt_top.sv
tb_mci_wdt_top.sv
